// ==== logic/gf64_pkg.sv ====
`default_nettype none

package gf64_pkg;

  localparam int field_width  = 6;
  localparam int gf4_width    = 2;
  localparam int rounds_width = 3;

  typedef enum logic [0:0] {
    addr_rounds,
    addr_mask
  } cfg_addr_e;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_finish
  } iter_state_e;

  // ############################################################
  // GF(4) base operations on tower coefficients
  // ############################################################

  function automatic logic [gf4_width-1:0] gf4_square(input logic [gf4_width-1:0] a);
    return {a[1], a[0] ^ a[1]};
  endfunction

  function automatic logic [gf4_width-1:0] gf4_add(input logic [gf4_width-1:0] a,
                                                   input logic [gf4_width-1:0] b);
    return a ^ b;
  endfunction

  function automatic logic [gf4_width-1:0] gf4_mul(input logic [gf4_width-1:0] a,
                                                   input logic [gf4_width-1:0] b);
    logic t;
    t = a[1] & b[1];
    return {(a[0] & b[1]) ^ (a[1] & b[0]) ^ t, (a[0] & b[0]) ^ t};
  endfunction

  // a^3 is 1 for any nonzero a, so this passes b or clears it
  function automatic logic [gf4_width-1:0] gf4_cube_scale(input logic [gf4_width-1:0] a,
                                                          input logic [gf4_width-1:0] b);
    logic t;
    t = a[0] ^ (~a[0] & a[1]);
    return {t & b[1], t & b[0]};
  endfunction

  // ############################################################
  // basis changes between polynomial and tower
  // ############################################################

  function automatic logic [field_width-1:0] to_tower(input logic [field_width-1:0] a);
    return {a[1] ^ a[2] ^ a[3] ^ a[5],
            a[0] ^ a[1] ^ a[5],
            a[2] ^ a[4],
            a[0] ^ a[2] ^ a[5],
            a[1] ^ a[4] ^ a[5],
            a[0] ^ a[2] ^ a[4] ^ a[5]};
  endfunction

  function automatic logic [field_width-1:0] from_tower(input logic [field_width-1:0] a);
    return {a[1] ^ a[2] ^ a[3] ^ a[4],
            a[0] ^ a[2],
            a[1] ^ a[3] ^ a[5],
            a[0] ^ a[2] ^ a[3],
            a[0] ^ a[3] ^ a[4],
            a[0] ^ a[1] ^ a[2] ^ a[4]};
  endfunction

endpackage

`default_nettype wire

// ==== logic/tower_power13.sv ====
`default_nettype none

module tower_power13 (
  input  wire logic [gf64_pkg::field_width-1:0] a,
  output logic      [gf64_pkg::field_width-1:0] b
);

  import gf64_pkg::*;

  logic [gf4_width-1:0] x0, x1, x2;       // input coefficients
  logic [gf4_width-1:0] sq0, sq1, sq2;    // squares
  logic [gf4_width-1:0] cs01, cs02, cs10, cs12, cs20, cs21;
  logic [gf4_width-1:0] m01, m02, m12;    // products of squares
  logic [gf4_width-1:0] p12, p02, p01;    // plain cross products
  logic [gf4_width-1:0] t0, t1, t2;       // square times cross product
  logic [gf4_width-1:0] c0, c1, c2;

  assign x0 = a[1:0];
  assign x1 = a[3:2];
  assign x2 = a[5:4];

  // ############################################################
  // shared terms
  // ############################################################

  assign sq0 = gf4_square(x0);
  assign sq1 = gf4_square(x1);
  assign sq2 = gf4_square(x2);

  assign cs01 = gf4_cube_scale(x0, x1);
  assign cs02 = gf4_cube_scale(x0, x2);
  assign cs10 = gf4_cube_scale(x1, x0);
  assign cs12 = gf4_cube_scale(x1, x2);
  assign cs20 = gf4_cube_scale(x2, x0);
  assign cs21 = gf4_cube_scale(x2, x1);

  assign m01 = gf4_mul(sq0, sq1);
  assign m02 = gf4_mul(sq0, sq2);
  assign m12 = gf4_mul(sq1, sq2);

  assign p12 = gf4_mul(x1, x2);
  assign p02 = gf4_mul(x0, x2);
  assign p01 = gf4_mul(x0, x1);

  assign t0 = gf4_mul(sq0, p12);
  assign t1 = gf4_mul(sq1, p02);
  assign t2 = gf4_mul(sq2, p01);

  // ############################################################
  // one sum per output coefficient
  // ############################################################

  always_comb begin
    c0 = gf4_add(x0, x1);
    c0 = gf4_add(c0, cs10);
    c0 = gf4_add(c0, cs12);
    c0 = gf4_add(c0, cs20);
    c0 = gf4_add(c0, m01);
    c0 = gf4_add(c0, m02);
    c0 = gf4_add(c0, t0);
    c0 = gf4_add(c0, t2);

    c1 = gf4_add(x1, x2);
    c1 = gf4_add(c1, cs01);
    c1 = gf4_add(c1, cs20);
    c1 = gf4_add(c1, cs21);
    c1 = gf4_add(c1, m01);
    c1 = gf4_add(c1, m12);
    c1 = gf4_add(c1, t0);
    c1 = gf4_add(c1, t1);

    c2 = gf4_add(x0, x2);
    c2 = gf4_add(c2, cs01);
    c2 = gf4_add(c2, cs02);
    c2 = gf4_add(c2, cs12);
    c2 = gf4_add(c2, m02);
    c2 = gf4_add(c2, m12);
    c2 = gf4_add(c2, t1);
    c2 = gf4_add(c2, t2);
  end

  assign b = {c2, c1, c0};

endmodule

`default_nettype wire

// ==== logic/sbox_cfg_regs.sv ====
`default_nettype none

module sbox_cfg_regs (
  input  wire logic                               clk,
  input  wire logic                               reset,
  input  wire logic                               cfg_write,
  input  wire gf64_pkg::cfg_addr_e                cfg_addr,
  input  wire logic [7:0]                         cfg_wdata,
  output logic      [7:0]                         cfg_rdata,
  output logic      [gf64_pkg::rounds_width-1:0]  rounds,
  output logic      [gf64_pkg::field_width-1:0]   mask
);

  import gf64_pkg::*;

  // ############################################################
  // register writes
  // ############################################################

  always_ff @(posedge clk) begin
    if (reset) begin
      rounds <= '0;
      mask   <= '0;
    end else if (cfg_write) begin
      case (cfg_addr)
        addr_rounds: rounds <= cfg_wdata[rounds_width-1:0];  // low bits only
        addr_mask:   mask   <= cfg_wdata[field_width-1:0];
        default:     ;
      endcase
    end
  end

  // zero-extended read-back
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      addr_rounds: cfg_rdata[rounds_width-1:0] = rounds;
      addr_mask:   cfg_rdata[field_width-1:0]  = mask;
      default:     cfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/sbox_iterator.sv ====
`default_nettype none

module sbox_iterator (
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  wire logic                                start,
  input  wire logic [gf64_pkg::field_width-1:0]    data_in,
  input  wire logic [gf64_pkg::rounds_width-1:0]   rounds,
  input  wire logic [gf64_pkg::field_width-1:0]    mask,
  output logic      [gf64_pkg::field_width-1:0]    data_out,
  output logic                                     busy,
  output logic                                     done
);

  import gf64_pkg::*;

  iter_state_e             state;
  logic [rounds_width-1:0] count;    // rounds still to go
  logic [field_width-1:0]  tower_q;  // operand in tower basis
  logic [field_width-1:0]  mask_q;   // mask snapshot
  logic [field_width-1:0]  core_out;
  logic                    take;
  logic                    step;

  tower_power13 core (
    .a (tower_q),
    .b (core_out)
  );

  assign take = (state == st_idle) && start;
  assign step = (state == st_run) && (count != '0);

  // ############################################################
  // control
  // ############################################################

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      count    <= '0;
      data_out <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_run;
            count <= rounds;
          end
        end
        st_run: begin
          if (count != '0) begin
            count <= count - 3'd1;
          end else begin
            data_out <= from_tower(tower_q) ^ mask_q;  // back to polynomial basis
            state    <= st_finish;
          end
        end
        st_finish: state <= st_idle;  // done lasts one cycle
        default:   state <= st_idle;
      endcase
    end
  end

  // ############################################################
  // operand path
  // ############################################################

  always_ff @(posedge clk) begin
    if (take) begin
      tower_q <= to_tower(data_in);
      mask_q  <= mask;
    end else if (step) begin
      tower_q <= core_out;  // one round of x^13
    end
  end

  assign busy = (state == st_run) || (state == st_finish);
  assign done = (state == st_finish);

endmodule

`default_nettype wire

// ==== logic/sbox_top.sv ====
`default_nettype none

module sbox_top (
  input  wire logic                              clk,
  input  wire logic                              reset,
  input  wire logic                              cfg_write,
  input  wire gf64_pkg::cfg_addr_e               cfg_addr,
  input  wire logic [7:0]                        cfg_wdata,
  output logic      [7:0]                        cfg_rdata,
  input  wire logic                              start,
  input  wire logic [gf64_pkg::field_width-1:0]  data_in,
  output logic      [gf64_pkg::field_width-1:0]  data_out,
  output logic                                   busy,
  output logic                                   done
);

  import gf64_pkg::*;

  logic [rounds_width-1:0] rounds;  // cfg to iterator
  logic [field_width-1:0]  mask;

  sbox_cfg_regs regs (
    .clk       (clk),
    .reset     (reset),
    .cfg_write (cfg_write),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .rounds    (rounds),
    .mask      (mask)
  );

  sbox_iterator iter (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .data_in  (data_in),
    .rounds   (rounds),
    .mask     (mask),
    .data_out (data_out),
    .busy     (busy),
    .done     (done)
  );

endmodule

`default_nettype wire

// ==== tests/sbox_props.sv ====
`default_nettype none

module sbox_props (
  input wire logic                   clk,
  input wire logic                   reset,
  input wire logic                   start,
  input wire logic                   busy,
  input wire logic                   done,
  input wire gf64_pkg::iter_state_e  state
);

  timeunit 1ns;
  timeprecision 100ps;

  import gf64_pkg::*;

  done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else $error("done high for two cycles in a row");

  done_then_idle: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
    else $error("busy still high in the cycle after done");

  reset_quiet: assert property (@(posedge clk) reset |=> (!busy && !done))
    else $error("busy or done high in the cycle after reset");

  start_to_run: assert property (@(posedge clk) disable iff (reset)
    (state == st_idle && start) |=> (state == st_run))
    else $error("start in idle did not lead to the run state");

endmodule

`default_nettype wire

// ==== tests/sbox_tb.sv ====
`default_nettype none

module sbox_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import gf64_pkg::*;

  logic                    clk;
  logic                    reset;
  logic                    cfg_write;
  cfg_addr_e               cfg_addr;
  logic [7:0]              cfg_wdata;
  logic [7:0]              cfg_rdata;
  logic                    start;
  logic [field_width-1:0]  data_in;
  logic [field_width-1:0]  data_out;
  logic                    busy;
  logic                    done;

  logic [31:0]             rng_state;
  int                      errors;
  int                      items;
  logic [rounds_width-1:0] model_rounds;             // register model
  logic [field_width-1:0]  model_mask;
  logic [field_width-1:0]  single_round [64];        // one-round results by input
  bit                      seen [64];

  sbox_top UUT (
    .clk       (clk),
    .reset     (reset),
    .cfg_write (cfg_write),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .start     (start),
    .data_in   (data_in),
    .data_out  (data_out),
    .busy      (busy),
    .done      (done)
  );

  bind sbox_iterator sbox_props props (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .busy  (busy),
    .done  (done),
    .state (state)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // ############################################################
  // helpers
  // ############################################################

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // k rounds by table lookup
  function automatic logic [field_width-1:0] apply_rounds(input logic [field_width-1:0] x,
                                                          input int k);
    logic [field_width-1:0] v;
    v = x;
    for (int i = 0; i < k; i++) begin
      v = single_round[v];
    end
    return v;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  task automatic write_reg(input cfg_addr_e addr, input logic [7:0] value);
    cfg_write = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = value;
    @(posedge clk);
    @(negedge clk);
    cfg_write = 1'b0;
    if (addr == addr_rounds) begin
      model_rounds = value[rounds_width-1:0];
    end else begin
      model_mask = value[field_width-1:0];
    end
  endtask

  task automatic check_regs();
    cfg_addr = addr_rounds;
    @(posedge clk);
    @(negedge clk);
    if (cfg_rdata !== {5'd0, model_rounds}) begin
      report_error($sformatf("rounds read %0h, expected %0h", cfg_rdata, model_rounds));
    end
    cfg_addr = addr_mask;
    @(posedge clk);
    @(negedge clk);
    if (cfg_rdata !== {2'd0, model_mask}) begin
      report_error($sformatf("mask read %0h, expected %0h", cfg_rdata, model_mask));
    end
  endtask

  task automatic wait_done(inout int edges);
    int limit;
    limit = edges + 32;  // longest item is 9 edges
    while (done !== 1'b1 && edges < limit) begin
      if (busy !== 1'b1) begin
        report_error("busy low while an item is in flight");
      end
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (done !== 1'b1) begin
      $display("timeout: done did not arrive within 32 clock edges");
      $display("Testbench failed");
      $finish;
    end
    if (busy !== 1'b1) begin
      report_error("busy low in the done cycle");
    end
  endtask

  // edges counts from the sampling edge, which is edge 1
  task automatic run_item(input logic [field_width-1:0] din,
                          output logic [field_width-1:0] dout, output int edges);
    start   = 1'b1;
    data_in = din;
    @(posedge clk);
    @(negedge clk);
    start = 1'b0;
    edges = 1;
    wait_done(edges);
    dout = data_out;
    items++;
    @(posedge clk);
    @(negedge clk);
    if (done !== 1'b0 || busy !== 1'b0) begin
      report_error("done or busy still high one cycle after done");
    end
    if (data_out !== dout) begin
      report_error($sformatf("data_out changed from %0h to %0h after done", dout, data_out));
    end
  endtask

  // ############################################################
  // stimulus
  // ############################################################

  initial begin
    logic [31:0]            r;
    logic [field_width-1:0] x;
    logic [field_width-1:0] x2;
    logic [field_width-1:0] m;
    logic [field_width-1:0] m2;
    logic [field_width-1:0] got;
    logic [field_width-1:0] expected;
    int                     k;
    int                     k2;
    int                     edges;

    reset        = 1'b1;
    cfg_write    = 1'b0;
    cfg_addr     = addr_rounds;
    cfg_wdata    = 8'd0;
    start        = 1'b0;
    data_in      = '0;
    rng_state    = 32'he0b1_8069;
    errors       = 0;
    items        = 0;
    model_rounds = '0;
    model_mask   = '0;
    for (int v = 0; v < 64; v++) begin
      seen[v]         = 1'b0;
      single_round[v] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    if (data_out !== 6'd0 || busy !== 1'b0 || done !== 1'b0) begin
      report_error("data_out, busy or done not cleared by reset");
    end

    // register write and read-back
    check_regs();
    for (int i = 0; i < 8; i++) begin
      next_rand(r);
      write_reg(cfg_addr_e'(i[0]), r[7:0]);
      check_regs();
    end

    // one round over the whole field
    write_reg(addr_rounds, 8'd1);
    write_reg(addr_mask, 8'd0);
    for (int v = 0; v < 64; v++) begin
      x = 6'(v);
      run_item(x, got, edges);
      if (edges != 3) begin
        report_error($sformatf("one round of %0d took %0d edges, expected 3", x, edges));
      end
      if (seen[got]) begin
        report_error($sformatf("one round maps %0d to %0d, value already taken", x, got));
      end
      seen[got]       = 1'b1;
      single_round[x] = got;
    end
    if (single_round[0] !== 6'd0) begin
      report_error($sformatf("one round maps 0 to %0d", single_round[0]));
    end
    if (single_round[1] !== 6'd1) begin
      report_error($sformatf("one round maps 1 to %0d", single_round[1]));
    end
    for (int v = 0; v < 64; v++) begin
      if (apply_rounds(6'(v), 6) !== 6'(v)) begin
        report_error($sformatf("six table rounds do not return %0d", v));
      end
    end

    // six rounds give the identity
    write_reg(addr_rounds, 8'd6);
    for (int i = 0; i < 16; i++) begin
      next_rand(r);
      x = r[5:0];
      run_item(x, got, edges);
      if (got !== x) begin
        report_error($sformatf("six rounds of %0d gave %0d", x, got));
      end
      if (edges != 8) begin
        report_error($sformatf("six rounds took %0d edges, expected 8", edges));
      end
    end

    // random round count and mask
    for (int i = 0; i < 24; i++) begin
      next_rand(r);
      k = (i == 0) ? 0 : r % 8;  // zero rounds at least once
      m = r[13:8];
      x = r[21:16];
      write_reg(addr_rounds, 8'(k));
      write_reg(addr_mask, {2'd0, m});
      expected = apply_rounds(x, k) ^ m;
      run_item(x, got, edges);
      if (got !== expected) begin
        report_error($sformatf("%0d rounds of %0d, mask %0h: got %0h, expected %0h",
                               k, x, m, got, expected));
      end
      if (edges != k + 2) begin
        report_error($sformatf("%0d rounds took %0d edges, expected %0d", k, edges, k + 2));
      end
    end

    // ############################################################
    // snapshot and ignored start
    // ############################################################

    next_rand(r);
    k = 3 + r % 5;
    m = r[13:8];
    x = r[21:16];
    write_reg(addr_rounds, 8'(k));
    write_reg(addr_mask, {2'd0, m});
    next_rand(r);
    k2 = r % 8;
    m2 = r[13:8];
    x2 = r[21:16];

    start   = 1'b1;
    data_in = x;
    @(posedge clk);
    @(negedge clk);
    data_in   = x2;  // start held high while busy
    cfg_write = 1'b1;
    cfg_addr  = addr_rounds;
    cfg_wdata = 8'(k2);
    @(posedge clk);
    @(negedge clk);
    start     = 1'b0;
    cfg_addr  = addr_mask;
    cfg_wdata = {2'd0, m2};
    @(posedge clk);
    @(negedge clk);
    cfg_write    = 1'b0;
    model_rounds = 3'(k2);
    model_mask   = m2;
    edges        = 3;
    wait_done(edges);
    items++;
    expected = apply_rounds(x, k) ^ m;
    if (data_out !== expected) begin
      report_error($sformatf("item in flight gave %0h, expected %0h", data_out, expected));
    end
    if (edges != k + 2) begin
      report_error($sformatf("item in flight took %0d edges, expected %0d", edges, k + 2));
    end
    @(posedge clk);
    @(negedge clk);
    if (busy !== 1'b0) begin
      report_error("busy high after done, second start was taken");
    end
    check_regs();

    expected = apply_rounds(x2, k2) ^ m2;
    run_item(x2, got, edges);
    if (got !== expected) begin
      report_error($sformatf("next item gave %0h, expected %0h", got, expected));
    end
    if (edges != k2 + 2) begin
      report_error($sformatf("next item took %0d edges, expected %0d", edges, k2 + 2));
    end

    $display("items run: %0d, errors: %0d", items, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/gf64_pkg.sv
logic/tower_power13.sv
logic/sbox_cfg_regs.sv
logic/sbox_iterator.sv
logic/sbox_top.sv
tests/sbox_props.sv
tests/sbox_tb.sv

// ==== Makefile ====
# Verilator build and run for the S-box engine

VERILATOR ?= verilator
TOP       ?= sbox_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	  if [ $$status -eq 0 ] && grep -qx "$(PASS_MSG)" $(LOG); then \
	    echo "pass message found in $(LOG)"; \
	  else \
	    echo "pass message missing from $(LOG)"; exit 1; \
	  fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
